// ==== design/link_reg_bank.sv ====
/*
  Register bank for the link statistics. Counts the event strobes
  of both monitors in wrapping counters and returns one register per
  read address, registered, one cycle after the address is sampled.
  Unmapped addresses read as all ones.
*/

`timescale 1ns/1ns
`include "link_stats_config.svh"

module link_reg_bank (
  input  logic                  clk,
  input  logic                  rst,

  // transmit monitor
  input  logic                  ev_sfrm,
  input  logic                  ev_lack,
  input  logic                  ev_lnak,
  input  logic                  ev_looc,
  input  logic [`CRDT_BITS-1:0] crdt,

  // receive monitor
  input  logic                  ev_crce,
  input  logic                  ev_frme,
  input  logic                  ev_dfrm,
  input  logic                  ev_rack,
  input  logic                  ev_rnak,
  input  logic                  ev_rooc,
  input  logic [`NUM_CHANS-1:0] cfcr,

  // register read port
  input  logic [`REGA_BITS-1:0] reg_addr,
  output logic [`REGD_BITS-1:0] reg_data
);

  import link_stats_pkg::*;

  // ----------------------------------------------------------------------
  // counter slots
  // ----------------------------------------------------------------------
  localparam int NUM_CTRS = 10;

  localparam int C_CRCE = 0;
  localparam int C_FRME = 1;
  localparam int C_LNAK = 2;
  localparam int C_RNAK = 3;
  localparam int C_LACK = 4;
  localparam int C_RACK = 5;
  localparam int C_LOOC = 6;
  localparam int C_ROOC = 7;
  localparam int C_SFRM = 8;
  localparam int C_DFRM = 9;

  logic [NUM_CTRS-1:0]   ev;
  logic [`REGD_BITS-1:0] ctr [NUM_CTRS];

  // gather strobes into one vector, one bit per counter
  assign ev[C_CRCE] = ev_crce;
  assign ev[C_FRME] = ev_frme;
  assign ev[C_LNAK] = ev_lnak;
  assign ev[C_RNAK] = ev_rnak;
  assign ev[C_LACK] = ev_lack;
  assign ev[C_RACK] = ev_rack;
  assign ev[C_LOOC] = ev_looc;
  assign ev[C_ROOC] = ev_rooc;
  assign ev[C_SFRM] = ev_sfrm;
  assign ev[C_DFRM] = ev_dfrm;

  // ----------------------------------------------------------------------
  // event counters
  // ----------------------------------------------------------------------
  // free running, wrap at the top, no back-pressure
  for (genvar i = 0; i < NUM_CTRS; i++) begin : g_ctr
    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        ctr[i] <= '0;
      end else if (ev[i]) begin
        ctr[i] <= ctr[i] + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // read mux
  // ----------------------------------------------------------------------
  // address sampled at an edge, data shows right after it
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      reg_data <= '0;
    end else begin
      case (reg_index_t'(reg_addr))
        reg_vers: reg_data <= `LINK_VERSION;
        reg_crce: reg_data <= ctr[C_CRCE];
        reg_frme: reg_data <= ctr[C_FRME];
        reg_lnak: reg_data <= ctr[C_LNAK];
        reg_rnak: reg_data <= ctr[C_RNAK];
        reg_lack: reg_data <= ctr[C_LACK];
        reg_rack: reg_data <= ctr[C_RACK];
        reg_looc: reg_data <= ctr[C_LOOC];
        reg_rooc: reg_data <= ctr[C_ROOC];
        // credit level, zero extended
        reg_crdt: reg_data <= {{(`REGD_BITS - `CRDT_BITS){1'b0}}, crdt};
        reg_sfrm: reg_data <= ctr[C_SFRM];
        reg_dfrm: reg_data <= ctr[C_DFRM];
        // stop mask, zero extended
        reg_cfcr: reg_data <= {{(`REGD_BITS - `NUM_CHANS){1'b0}}, cfcr};
        // unmapped
        default:  reg_data <= {`REGD_BITS{1'b1}};
      endcase
    end
  end

endmodule

// ==== design/link_stats_config.svh ====
/*
  Width and limit settings for the link statistics block.
  Included by every RTL file and by the testbench so that all of
  them agree on register, address, credit and channel sizes.
*/

`ifndef LINK_STATS_CONFIG_SVH
`define LINK_STATS_CONFIG_SVH

// ----------------------------------------------------------------------
// register access
// ----------------------------------------------------------------------

// register and counter width
`define REGD_BITS 32

// read address width, 32 addresses
`define REGA_BITS 5

// value returned at the version address
`define LINK_VERSION 32'h0001_0203

// ----------------------------------------------------------------------
// flow control
// ----------------------------------------------------------------------

// local credit level width
`define CRDT_BITS 4

// credit after reset, also the saturation ceiling
`define CRDT_MAX 12

// channels covered by the remote stop mask
`define NUM_CHANS 8

`endif

// ==== design/link_stats_pkg.sv ====
/*
  Shared types for the link statistics block: the frame kind code
  carried in the top bits of a frame word, and the read address map
  of the register bank.
*/

`include "link_stats_config.svh"

package link_stats_pkg;

  // ----------------------------------------------------------------------
  // frame kind
  // ----------------------------------------------------------------------
  // received word layout
  //   [31:29] kind
  //   [28:16] payload, not looked at here
  //   [15:8]  channel mask, used by ooc frames
  //   [7:0]   checksum, xor of the three upper bytes
  // codes 4 to 7 are reserved and count as framing errors
  typedef enum logic [2:0] {
    kind_data = 3'd0,
    kind_ack  = 3'd1,
    kind_nak  = 3'd2,
    kind_ooc  = 3'd3
  } frame_kind_t;

  // ----------------------------------------------------------------------
  // register map
  // ----------------------------------------------------------------------
  // addresses 13 and up are unmapped, they read as all ones
  typedef enum logic [`REGA_BITS-1:0] {
    reg_vers = 5'd0,
    reg_crce = 5'd1,
    reg_frme = 5'd2,
    reg_lnak = 5'd3,
    reg_rnak = 5'd4,
    reg_lack = 5'd5,
    reg_rack = 5'd6,
    reg_looc = 5'd7,
    reg_rooc = 5'd8,
    // level, not a counter
    reg_crdt = 5'd9,
    reg_sfrm = 5'd10,
    reg_dfrm = 5'd11,
    // level, not a counter
    reg_cfcr = 5'd12
  } reg_index_t;

endpackage

// ==== design/link_stats_top.sv ====
/*
  Top level of the link statistics block. The two link monitors run
  side by side and feed their strobes and levels into the register
  bank. A frame shows up in a read addressed two edges later.
*/

`timescale 1ns/1ns
`include "link_stats_config.svh"

module link_stats_top (
  input  logic                        clk,
  input  logic                        rst,

  // transmit side
  input  logic                        tx_vld,
  input  link_stats_pkg::frame_kind_t tx_kind,
  input  logic                        crdt_ret,

  // receive side
  input  logic                        rx_vld,
  input  logic [31:0]                 rx_word,

  // register read port
  input  logic [`REGA_BITS-1:0]       reg_addr,
  output logic [`REGD_BITS-1:0]       reg_data
);

  // transmit monitor results
  logic                  ev_sfrm;
  logic                  ev_lack;
  logic                  ev_lnak;
  logic                  ev_looc;
  logic [`CRDT_BITS-1:0] crdt;

  // receive monitor results
  logic                  ev_crce;
  logic                  ev_frme;
  logic                  ev_dfrm;
  logic                  ev_rack;
  logic                  ev_rnak;
  logic                  ev_rooc;
  logic [`NUM_CHANS-1:0] cfcr;

  // ----------------------------------------------------------------------
  // monitors
  // ----------------------------------------------------------------------

  tx_link_monitor u_tx_mon (
    .clk      (clk),
    .rst      (rst),
    .tx_vld   (tx_vld),
    .tx_kind  (tx_kind),
    .crdt_ret (crdt_ret),
    .ev_sfrm  (ev_sfrm),
    .ev_lack  (ev_lack),
    .ev_lnak  (ev_lnak),
    .ev_looc  (ev_looc),
    .crdt     (crdt)
  );

  rx_link_monitor u_rx_mon (
    .clk     (clk),
    .rst     (rst),
    .rx_vld  (rx_vld),
    .rx_word (rx_word),
    .ev_crce (ev_crce),
    .ev_frme (ev_frme),
    .ev_dfrm (ev_dfrm),
    .ev_rack (ev_rack),
    .ev_rnak (ev_rnak),
    .ev_rooc (ev_rooc),
    .cfcr    (cfcr)
  );

  // ----------------------------------------------------------------------
  // register bank
  // ----------------------------------------------------------------------

  link_reg_bank u_regs (
    .clk      (clk),
    .rst      (rst),
    .ev_sfrm  (ev_sfrm),
    .ev_lack  (ev_lack),
    .ev_lnak  (ev_lnak),
    .ev_looc  (ev_looc),
    .crdt     (crdt),
    .ev_crce  (ev_crce),
    .ev_frme  (ev_frme),
    .ev_dfrm  (ev_dfrm),
    .ev_rack  (ev_rack),
    .ev_rnak  (ev_rnak),
    .ev_rooc  (ev_rooc),
    .cfcr     (cfcr),
    .reg_addr (reg_addr),
    .reg_data (reg_data)
  );

endmodule

// ==== design/rx_link_monitor.sv ====
/*
  Receive side monitor. Checks each received frame word for a
  checksum error, then for a reserved kind, and classifies the good
  ones. Also keeps the remote channel stop mask built up from ooc
  frames. Outputs follow the sampling edge by one cycle.
*/

`timescale 1ns/1ns
`include "link_stats_config.svh"

module rx_link_monitor (
  input  logic                  clk,
  input  logic                  rst,

  // received frame word, valid with the strobe
  input  logic                  rx_vld,
  input  logic [31:0]           rx_word,

  // event strobes to the register bank
  output logic                  ev_crce,
  output logic                  ev_frme,
  output logic                  ev_dfrm,
  output logic                  ev_rack,
  output logic                  ev_rnak,
  output logic                  ev_rooc,

  // remote channel stop mask
  output logic [`NUM_CHANS-1:0] cfcr
);

  import link_stats_pkg::*;

  frame_kind_t           kind;
  logic [7:0]            csum_calc;
  logic                  csum_ok;
  logic                  kind_known;
  logic [`NUM_CHANS-1:0] chan_mask;
  logic                  good;
  logic                  good_ack;
  logic                  good_nak;
  logic                  good_ooc;

  // ----------------------------------------------------------------------
  // field split
  // ----------------------------------------------------------------------

  assign kind      = frame_kind_t'(rx_word[31:29]);
  assign chan_mask = rx_word[8 +: `NUM_CHANS];

  // checksum covers kind, payload and channel mask bytes
  assign csum_calc = rx_word[31:24] ^ rx_word[23:16] ^ rx_word[15:8];
  assign csum_ok   = (csum_calc == rx_word[7:0]);

  // only the four defined codes are legal
  always_comb begin
    case (kind)
      kind_data, kind_ack, kind_nak, kind_ooc: kind_known = 1'b1;
      default:                                 kind_known = 1'b0;
    endcase
  end

  // ----------------------------------------------------------------------
  // classification
  // ----------------------------------------------------------------------
  // checksum first, kind second, a word raises one error at most
  assign good     = rx_vld && csum_ok && kind_known;
  assign good_ack = good && (kind == kind_ack);
  assign good_nak = good && (kind == kind_nak);
  assign good_ooc = good && (kind == kind_ooc);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ev_crce <= 1'b0;
      ev_frme <= 1'b0;
      ev_dfrm <= 1'b0;
      ev_rack <= 1'b0;
      ev_rnak <= 1'b0;
      ev_rooc <= 1'b0;
    end else begin
      // bad checksum hides everything else
      ev_crce <= rx_vld && !csum_ok;
      // clean word with a reserved kind
      ev_frme <= rx_vld && csum_ok && !kind_known;
      // any valid frame, plus its kind strobe
      ev_dfrm <= good;
      ev_rack <= good_ack;
      ev_rnak <= good_nak;
      ev_rooc <= good_ooc;
    end
  end

  // ----------------------------------------------------------------------
  // remote stop mask
  // ----------------------------------------------------------------------
  // ooc stops the channels in its mask, ack releases all of them
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cfcr <= '0;
    end else if (good_ack) begin
      cfcr <= '0;
    end else if (good_ooc) begin
      cfcr <= cfcr | chan_mask;
    end
  end

endmodule

// ==== design/tx_link_monitor.sv ====
/*
  Transmit side monitor. Watches frames leaving the local assembler,
  raises one event strobe per classified frame and keeps the local
  credit level. Events and credit follow the sampling edge by one
  cycle.
*/

`timescale 1ns/1ns
`include "link_stats_config.svh"

module tx_link_monitor (
  input  logic                        clk,
  input  logic                        rst,

  // sent frame, one strobe per frame
  input  logic                        tx_vld,
  input  link_stats_pkg::frame_kind_t tx_kind,

  // one credit handed back by the far end
  input  logic                        crdt_ret,

  // event strobes to the register bank
  output logic                        ev_sfrm,
  output logic                        ev_lack,
  output logic                        ev_lnak,
  output logic                        ev_looc,

  // current local credit
  output logic [`CRDT_BITS-1:0]       crdt
);

  import link_stats_pkg::*;

  logic                 is_data;
  logic                 crdt_zero;
  logic                 crdt_take;
  logic [`CRDT_BITS:0]  crdt_sum;
  logic [`CRDT_BITS-1:0] crdt_nxt;

  // ----------------------------------------------------------------------
  // frame decode
  // ----------------------------------------------------------------------

  assign is_data   = tx_vld && (tx_kind == kind_data);
  assign crdt_zero = (crdt == '0);

  // data frame only spends a credit when one is left
  assign crdt_take = is_data && !crdt_zero;

  // ----------------------------------------------------------------------
  // credit update
  // ----------------------------------------------------------------------
  // return and spend in one cycle both count from the old level
  // one extra bit so old + 1 cannot wrap before the clamp
  assign crdt_sum = {1'b0, crdt}
                  + {{`CRDT_BITS{1'b0}}, crdt_ret}
                  - {{`CRDT_BITS{1'b0}}, crdt_take};

  // saturate at the ceiling
  assign crdt_nxt = (crdt_sum > `CRDT_MAX) ? `CRDT_BITS'(`CRDT_MAX)
                                           : crdt_sum[`CRDT_BITS-1:0];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      // link starts with a full credit window
      crdt <= `CRDT_BITS'(`CRDT_MAX);
    end else begin
      crdt <= crdt_nxt;
    end
  end

  // ----------------------------------------------------------------------
  // event strobes
  // ----------------------------------------------------------------------
  // one cycle high per frame
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ev_sfrm <= 1'b0;
      ev_looc <= 1'b0;
      ev_lack <= 1'b0;
      ev_lnak <= 1'b0;
    end else begin
      // data frame sent with credit
      ev_sfrm <= crdt_take;
      // data frame attempted at zero credit
      ev_looc <= is_data && crdt_zero;
      // local ack and nak
      ev_lack <= tx_vld && (tx_kind == kind_ack);
      ev_lnak <= tx_vld && (tx_kind == kind_nak);
      // ooc and reserved kinds raise nothing here
    end
  end

endmodule

// ==== link_stats_top.f ====
+incdir+design
design/link_stats_pkg.sv
design/tx_link_monitor.sv
design/rx_link_monitor.sv
design/link_reg_bank.sv
design/link_stats_top.sv
verif/link_stats_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the link statistics testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f link_stats_top.f \
  --top-module link_stats_tb \
  -o link_stats_sim

# the simulator exits non-zero on a failed check, the log decides
./obj_dir/link_stats_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation finished without failures"

// ==== verif/link_stats_tb.sv ====
/*
  Testbench for the link statistics block. Drives random and directed
  transmit and receive traffic on the falling edge, keeps its own
  model of every register, and checks a full read sweep after each
  phase, including a reset in the middle of the run.
*/

`timescale 1ns/1ns
`include "link_stats_config.svh"

module link_stats_tb;

  import link_stats_pkg::*;

  // cycles allowed for the bank to show the version after reset
  localparam int MAX_WAIT = 16;

  logic                  clk;
  logic                  rst;
  logic                  tx_vld;
  frame_kind_t           tx_kind;
  logic                  crdt_ret;
  logic                  rx_vld;
  logic [31:0]           rx_word;
  logic [`REGA_BITS-1:0] reg_addr;
  logic [`REGD_BITS-1:0] reg_data;

  // model state, counters indexed by read address
  logic [`REGD_BITS-1:0] m_cnt [13];
  int                    m_crdt;
  logic [`NUM_CHANS-1:0] m_cfcr;

  link_stats_top DUT (
    .clk      (clk),
    .rst      (rst),
    .tx_vld   (tx_vld),
    .tx_kind  (tx_kind),
    .crdt_ret (crdt_ret),
    .rx_vld   (rx_vld),
    .rx_word  (rx_word),
    .reg_addr (reg_addr),
    .reg_data (reg_data)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------

  task automatic model_reset();
    for (int i = 0; i < 13; i++) begin
      m_cnt[i] = '0;
    end
    m_crdt = `CRDT_MAX;
    m_cfcr = '0;
  endtask

  function automatic logic [`REGD_BITS-1:0] expected_reg(input int a);
    if (a == reg_vers) return `LINK_VERSION;
    else if (a == reg_crdt) return `REGD_BITS'(m_crdt);
    else if (a == reg_cfcr) return {{(`REGD_BITS - `NUM_CHANS){1'b0}}, m_cfcr};
    else if (a < 13) return m_cnt[a];
    // unmapped addresses
    else return '1;
  endfunction

  // word with a good checksum unless corrupt is set
  function automatic logic [31:0] make_word(input logic [2:0] kind, input logic [7:0] mask,
                                            input bit corrupt);
    logic [31:0] w;
    logic [7:0]  flip;
    w[31:29] = kind;
    w[28:16] = 13'($urandom);
    w[15:8]  = mask;
    w[7:0]   = w[31:24] ^ w[23:16] ^ w[15:8];
    // nonzero, so a corrupted checksum never matches by luck
    flip = 8'($urandom_range(1, 255));
    if (corrupt) w[7:0] = w[7:0] ^ flip;
    return w;
  endfunction

  // ----------------------------------------------------------------------
  // drivers, called right after a falling edge
  // ----------------------------------------------------------------------

  task automatic drive_tx(input bit vld, input logic [2:0] kind, input bit ret);
    bit take;
    int nxt;
    take     = 1'b0;
    tx_vld   = vld;
    tx_kind  = frame_kind_t'(kind);
    crdt_ret = ret;
    if (vld) begin
      case (kind)
        3'd0: begin
          // data frame spends a credit, or is out of credit
          if (m_crdt > 0) begin
            take = 1'b1;
            m_cnt[reg_sfrm]++;
          end else begin
            m_cnt[reg_looc]++;
          end
        end
        3'd1: m_cnt[reg_lack]++;
        3'd2: m_cnt[reg_lnak]++;
        default: ;
      endcase
    end
    // return and spend both from the old level, then clamp
    nxt = m_crdt + (ret ? 1 : 0) - (take ? 1 : 0);
    if (nxt > `CRDT_MAX) nxt = `CRDT_MAX;
    m_crdt = nxt;
  endtask

  task automatic drive_rx(input bit vld, input logic [2:0] kind, input logic [7:0] mask,
                          input bit bad);
    rx_vld  = vld;
    rx_word = vld ? make_word(kind, mask, bad) : '0;
    if (vld) begin
      if (bad) begin
        m_cnt[reg_crce]++;
      end else if (kind > 3'd3) begin
        m_cnt[reg_frme]++;
      end else begin
        m_cnt[reg_dfrm]++;
        case (kind)
          3'd1: begin
            m_cnt[reg_rack]++;
            m_cfcr = '0;
          end
          3'd2: m_cnt[reg_rnak]++;
          3'd3: begin
            m_cnt[reg_rooc]++;
            m_cfcr = m_cfcr | mask;
          end
          default: ;
        endcase
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
    end
  endtask

  // percentages pick the traffic mix for each cycle
  task automatic run_traffic(input int n, input int tx_pct, input int data_pct,
                             input int ret_pct, input int rx_pct, input int bad_pct,
                             input int rsv_pct);
    bit         tv;
    logic [2:0] tk;
    bit         rv;
    logic [2:0] rk;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      tv = ($urandom_range(0, 99) < tx_pct);
      tk = ($urandom_range(0, 99) < data_pct) ? 3'd0 : 3'($urandom_range(1, 7));
      drive_tx(tv, tk, $urandom_range(0, 99) < ret_pct);
      rv = ($urandom_range(0, 99) < rx_pct);
      rk = ($urandom_range(0, 99) < rsv_pct) ? 3'($urandom_range(4, 7))
                                             : 3'($urandom_range(0, 3));
      drive_rx(rv, rk, 8'($urandom), $urandom_range(0, 99) < bad_pct);
    end
  endtask

  task automatic send_rx_frame(input logic [2:0] kind, input logic [7:0] mask);
    @(negedge clk);
    drive_tx(1'b0, 3'd0, 1'b0);
    drive_rx(1'b1, kind, mask, 1'b0);
  endtask

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------

  task automatic check_reg(input int a);
    logic [`REGD_BITS-1:0] exp;
    exp = expected_reg(a);
    assert (reg_data === exp)
      else begin
        $display("mismatch reg_data addr %h: got %h, expected %h", a, reg_data, exp);
        $display("TEST FAILED");
        $fatal(1, "register read check failed");
      end
  endtask

  // read port is cleared while reset is held
  task automatic check_reset_data();
    logic [`REGD_BITS-1:0] exp;
    exp = '0;
    assert (reg_data === exp)
      else begin
        $display("mismatch reg_data in reset: got %h, expected %h", reg_data, exp);
        $display("TEST FAILED");
        $fatal(1, "reset value check failed");
      end
  endtask

  // two quiet cycles, then one read per address
  task automatic sweep_regs();
    @(negedge clk);
    drive_tx(1'b0, 3'd0, 1'b0);
    drive_rx(1'b0, 3'd0, 8'd0, 1'b0);
    idle_cycles(2);
    for (int a = 0; a < 32; a++) begin
      reg_addr = `REGA_BITS'(a);
      @(negedge clk);
      check_reg(a);
    end
  endtask

  task automatic wait_version();
    int cnt;
    cnt      = 0;
    reg_addr = '0;
    @(negedge clk);
    while (reg_data !== `LINK_VERSION) begin
      if (cnt == MAX_WAIT) begin
        $display("register bank never returned the version value after reset");
        $display("TEST FAILED");
        $fatal(1, "reset wait timed out");
      end
      cnt++;
      @(negedge clk);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    drive_tx(1'b0, 3'd0, 1'b0);
    drive_rx(1'b0, 3'd0, 8'd0, 1'b0);
    model_reset();
    idle_cycles(2);
    check_reset_data();
    rst = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------

  initial begin
    void'($urandom(32'h562536ee));
    clk      = 1'b0;
    rst      = 1'b1;
    tx_vld   = 1'b0;
    tx_kind  = kind_data;
    crdt_ret = 1'b0;
    rx_vld   = 1'b0;
    rx_word  = '0;
    reg_addr = '0;
    model_reset();
    idle_cycles(2);
    check_reset_data();
    rst = 1'b0;
    wait_version();
    sweep_regs();

    // drain the credit and keep sending at zero
    run_traffic(60, 90, 90, 10, 0, 0, 0);
    sweep_regs();
    // refill until the ceiling holds
    run_traffic(60, 40, 30, 90, 0, 0, 0);
    sweep_regs();

    // corrupted words only
    run_traffic(40, 0, 0, 0, 90, 100, 0);
    sweep_regs();
    // clean words with reserved kinds
    run_traffic(40, 0, 0, 0, 90, 0, 100);
    sweep_regs();
    // clean words with defined kinds
    run_traffic(80, 0, 0, 0, 90, 0, 0);
    sweep_regs();

    // start from an empty mask, let it build up, then an ack clears it
    send_rx_frame(3'd1, 8'h00);
    send_rx_frame(3'd3, 8'h05);
    send_rx_frame(3'd3, 8'h30);
    send_rx_frame(3'd3, 8'h81);
    sweep_regs();
    send_rx_frame(3'd1, 8'h00);
    sweep_regs();

    // both sides busy at once
    run_traffic(200, 70, 60, 50, 70, 20, 15);
    sweep_regs();

    // reset in the middle of the run
    apply_reset();
    wait_version();
    sweep_regs();
    run_traffic(50, 60, 60, 40, 60, 20, 20);
    sweep_regs();

    $display("TEST PASSED");
    $finish;
  end

endmodule
